/* backingStore.sv */
// Backing word store
`timescale 1ns/10ps
`default_nettype none

module backingStore #(
    parameter int AddrWidth = cachePkg::AddrWidth,
    parameter int DataWidth = cachePkg::DataWidth
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 lookValid,
    input  wire logic                 lookWrite,
    input  wire logic [AddrWidth-1:0] lookAddr,
    input  wire logic [DataWidth-1:0] lookData,
    output logic                      memValid,
    output logic      [DataWidth-1:0] memData
);

    localparam int WordCount = 2 ** AddrWidth;

    logic [DataWidth-1:0] words [WordCount];

    // The whole store starts out as zero words
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < WordCount; i++) begin
                words[i] <= '0;
            end
        end else if (lookValid && lookWrite) begin
            words[lookAddr] <= lookData;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            memValid <= 1'b0;
        end else begin
            memValid <= lookValid;
        end
    end

    // A write answers with the word it stores, a read with the old contents
    always_ff @(posedge clk) begin
        if (lookValid) begin
            memData <= lookWrite ? lookData : words[lookAddr];
        end
    end

endmodule

`default_nettype wire

/* cachePkg.sv */
// Cache shared definitions
`default_nettype none

package cachePkg;

    // Request address width, 64 words in the backing store
    localparam int AddrWidth = 6;

    // Data word width
    localparam int DataWidth = 16;

    // Number of fully associative cache cells
    localparam int CellCount = 4;

    // A cell holds the address in the upper bits and the word in the lower bits
    localparam int EntryWidth = AddrWidth + DataWidth;

    // Width of the update kind code sent from the merge to the cache
    localparam int KindWidth = 2;

    // Move a resident entry back to the newest position
    localparam logic [KindWidth-1:0] UpdPromote = 2'd0;

    // Bring a missed read word in as the newest entry
    localparam logic [KindWidth-1:0] UpdFill = 2'd1;

    // Bring a written word in as the newest entry
    localparam logic [KindWidth-1:0] UpdInsert = 2'd2;

endpackage

`default_nettype wire

/* cacheTb.sv */
// LRU cache testbench
`timescale 1ns/10ps
`default_nettype none

module cacheTb;

    localparam int AddrWidth = cachePkg::AddrWidth;
    localparam int DataWidth = cachePkg::DataWidth;
    localparam int CellCount = cachePkg::CellCount;
    localparam int ClockPeriod = 40;
    // Requests over all tests: 3 + 4 + 6 + 6 + 2 + 200
    localparam int RequestCount = 221;

    logic                 clk;
    logic                 rst;
    logic                 reqValid;
    logic                 reqWrite;
    logic [AddrWidth-1:0] reqAddr;
    logic [DataWidth-1:0] reqData;
    logic                 rspReady;
    logic                 reqReady;
    logic                 rspValid;
    logic [DataWidth-1:0] rspData;
    logic                 rspHit;

    int errorCount = 0;
    int testCount = 0;
    int failedTests = 0;
    int seed = 38;

    // Reference model: word array and address list, newest first
    logic [DataWidth-1:0] refMem [2**AddrWidth];
    logic [AddrWidth-1:0] refOrder [$];

    tbClock #(
        .ClockPeriod(ClockPeriod),
        .ResetCycles(4)
    ) uClock (
        .clk(clk),
        .rst(rst)
    );

    cacheTop #(
        .AddrWidth(AddrWidth),
        .DataWidth(DataWidth),
        .CellCount(CellCount)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .reqWrite(reqWrite),
        .reqAddr(reqAddr),
        .reqData(reqData),
        .rspReady(rspReady),
        .reqReady(reqReady),
        .rspValid(rspValid),
        .rspData(rspData),
        .rspHit(rspHit)
    );

    task automatic compareData(input logic [DataWidth-1:0] got, input logic [DataWidth-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s data %h, expected %h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic compareHit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s hit flag %b, expected %b", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("Problem at %0t ns: %s", $time, msg);
        errorCount++;
    endtask

    task automatic modelAccess(input logic write, input logic [AddrWidth-1:0] addr,
                               input logic [DataWidth-1:0] data,
                               output logic [DataWidth-1:0] expData, output logic expHit);
        int pos;
        pos = -1;
        foreach (refOrder[i]) begin
            if (refOrder[i] == addr) begin
                pos = i;
            end
        end
        expHit = (pos >= 0);
        if (write) begin
            refMem[addr] = data;
        end
        expData = refMem[addr];
        if (pos >= 0) begin
            refOrder.delete(pos);
        end
        refOrder.push_front(addr);
        if (refOrder.size() > CellCount) begin
            refOrder.delete(refOrder.size() - 1);
        end
    endtask

    // Called 2 ns after a rising edge, returns at the same point of a later cycle
    task automatic transact(input logic write, input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] data,
                            output logic [DataWidth-1:0] gotData, output logic gotHit);
        reqValid = 1'b1;
        reqWrite = write;
        reqAddr = addr;
        reqData = data;
        while (!reqReady) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        reqValid = 1'b0;
        while (!rspValid) begin
            @(posedge clk);
            #2;
        end
        gotData = rspData;
        gotHit = rspHit;
        @(posedge clk);
        #2;
    endtask

    task automatic checkAccess(input logic write, input logic [AddrWidth-1:0] addr,
                               input logic [DataWidth-1:0] data,
                               output logic [DataWidth-1:0] gotData, output logic gotHit);
        logic [DataWidth-1:0] expData;
        logic                 expHit;
        modelAccess(write, addr, data, expData, expHit);
        transact(write, addr, data, gotData, gotHit);
        compareData(gotData, expData, $sformatf("%s of %0d", write ? "write" : "read", addr));
        compareHit(gotHit, expHit, $sformatf("%s of %0d", write ? "write" : "read", addr));
    endtask

    task automatic finishTest(input string name, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("%s: ok", name);
        end else begin
            failedTests++;
            $display("%s: %0d errors", name, errorCount - startErrors);
        end
    endtask

    task automatic readAfterReset();
        logic [DataWidth-1:0] gotData;
        logic                 gotHit;
        int                   startErrors;
        startErrors = errorCount;
        checkAccess(1'b0, 6'd5, '0, gotData, gotHit);
        compareData(gotData, '0, "first read after reset");
        compareHit(gotHit, 1'b0, "first read after reset");
        checkAccess(1'b0, 6'd5, '0, gotData, gotHit);
        compareHit(gotHit, 1'b1, "repeated read");
        checkAccess(1'b0, 6'd40, '0, gotData, gotHit);
        compareData(gotData, '0, "second address after reset");
        finishTest("reset read", startErrors);
    endtask

    task automatic writeThenRead();
        logic [DataWidth-1:0] gotData;
        logic                 gotHit;
        logic [DataWidth-1:0] word;
        int                   startErrors;
        startErrors = errorCount;
        word = DataWidth'($random(seed));
        checkAccess(1'b1, 6'd12, word, gotData, gotHit);
        checkAccess(1'b0, 6'd12, '0, gotData, gotHit);
        compareData(gotData, word, "read after write");
        compareHit(gotHit, 1'b1, "read after write");
        // Writing a resident address replaces its cell
        word = DataWidth'($random(seed));
        checkAccess(1'b1, 6'd5, word, gotData, gotHit);
        checkAccess(1'b0, 6'd5, '0, gotData, gotHit);
        compareData(gotData, word, "read after overwrite");
        finishTest("write read", startErrors);
    endtask

    task automatic evictOldest();
        logic [DataWidth-1:0] gotData;
        logic                 gotHit;
        logic [DataWidth-1:0] firstWord;
        logic [DataWidth-1:0] word;
        int                   startErrors;
        startErrors = errorCount;
        firstWord = '0;
        for (int i = 0; i < 5; i++) begin
            word = DataWidth'($random(seed));
            if (i == 0) begin
                firstWord = word;
            end
            checkAccess(1'b1, AddrWidth'(20 + i), word, gotData, gotHit);
        end
        checkAccess(1'b0, 6'd20, '0, gotData, gotHit);
        compareHit(gotHit, 1'b0, "evicted address");
        compareData(gotData, firstWord, "evicted address");
        finishTest("eviction", startErrors);
    endtask

    task automatic promoteOnHit();
        logic [DataWidth-1:0] gotData;
        logic                 gotHit;
        int                   startErrors;
        startErrors = errorCount;
        // Address 22 is the oldest entry at this point
        checkAccess(1'b0, 6'd22, '0, gotData, gotHit);
        compareHit(gotHit, 1'b1, "oldest entry");
        for (int i = 0; i < 3; i++) begin
            checkAccess(1'b1, AddrWidth'(30 + i), DataWidth'($random(seed)), gotData, gotHit);
        end
        checkAccess(1'b0, 6'd22, '0, gotData, gotHit);
        compareHit(gotHit, 1'b1, "promoted entry");
        checkAccess(1'b0, 6'd20, '0, gotData, gotHit);
        compareHit(gotHit, 1'b0, "entry evicted instead");
        finishTest("promotion", startErrors);
    endtask

    task automatic stallResponse();
        logic [DataWidth-1:0] expData;
        logic                 expHit;
        logic [DataWidth-1:0] heldData;
        logic                 heldHit;
        logic [DataWidth-1:0] gotData;
        logic                 gotHit;
        int                   startErrors;
        startErrors = errorCount;
        modelAccess(1'b0, 6'd31, '0, expData, expHit);
        rspReady = 1'b0;
        reqValid = 1'b1;
        reqWrite = 1'b0;
        reqAddr = 6'd31;
        reqData = '0;
        while (!reqReady) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        // A second request is offered while the first one is outstanding
        reqAddr = 6'd3;
        while (!rspValid) begin
            @(posedge clk);
            #2;
        end
        heldData = rspData;
        heldHit = rspHit;
        repeat (6) begin
            @(posedge clk);
            #2;
            compareData(rspData, heldData, "stalled response");
            compareHit(rspHit, heldHit, "stalled response");
            if (!rspValid) begin
                reportProblem("response valid dropped while ready was held low");
            end
            if (reqReady) begin
                reportProblem("request port became ready during a stalled response");
            end
        end
        reqValid = 1'b0;
        rspReady = 1'b1;
        @(posedge clk);
        #2;
        compareData(heldData, expData, "released response");
        compareHit(heldHit, expHit, "released response");
        checkAccess(1'b0, 6'd31, '0, gotData, gotHit);
        finishTest("back-pressure", startErrors);
    endtask

    task automatic randomMix();
        logic [DataWidth-1:0] gotData;
        logic                 gotHit;
        logic [31:0]          pick;
        int                   startErrors;
        startErrors = errorCount;
        repeat (200) begin
            pick = $random(seed);
            checkAccess(pick[0], AddrWidth'(pick[3:1]), DataWidth'($random(seed)),
                        gotData, gotHit);
        end
        finishTest("random mix", startErrors);
    endtask

    initial begin
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr = '0;
        reqData = '0;
        rspReady = 1'b1;
        foreach (refMem[i]) begin
            refMem[i] = '0;
        end
        @(negedge rst);
        @(posedge clk);
        #2;
        readAfterReset();
        writeThenRead();
        evictOldest();
        promoteOnHit();
        stallResponse();
        randomMix();
        if (i_dut.uAsserts.assertFailures != 0) begin
            $display("Handshake assertions failed %0d times", i_dut.uAsserts.assertFailures);
            errorCount += i_dut.uAsserts.assertFailures;
        end
        $display("tests %0d, failed tests %0d, errors %0d", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Twenty cycles per request is far beyond the five a transaction needs
    initial begin
        #(RequestCount * 20 * ClockPeriod);
        $display("Timeout: the tests did not finish in the expected time");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* cacheTop.sv */
// LRU cache top level
`timescale 1ns/10ps
`default_nettype none

module cacheTop #(
    parameter int AddrWidth = cachePkg::AddrWidth,
    parameter int DataWidth = cachePkg::DataWidth,
    parameter int CellCount = cachePkg::CellCount
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 reqValid,
    input  wire logic                 reqWrite,
    input  wire logic [AddrWidth-1:0] reqAddr,
    input  wire logic [DataWidth-1:0] reqData,
    input  wire logic                 rspReady,
    output logic                      reqReady,
    output logic                      rspValid,
    output logic      [DataWidth-1:0] rspData,
    output logic                      rspHit
);

    localparam int IndexWidth = $clog2(CellCount);

    logic                           lookValid;
    logic                           hitValid;
    logic                           hit;
    logic [DataWidth-1:0]           hitData;
    logic [IndexWidth-1:0]          hitIndex;
    logic                           memValid;
    logic [DataWidth-1:0]           memData;
    logic                           updValid;
    logic [cachePkg::KindWidth-1:0] updKind;
    logic [IndexWidth-1:0]          updIndex;
    logic [AddrWidth-1:0]           updAddr;
    logic [DataWidth-1:0]           updData;
    logic                           busy;

    // Only one transaction is in flight, so a request is taken only when idle
    assign reqReady = !busy;
    assign lookValid = reqValid && reqReady;

    // Cache search and backing store read run side by side
    lruCache #(
        .AddrWidth(AddrWidth),
        .DataWidth(DataWidth),
        .CellCount(CellCount)
    ) uLruCache (
        .clk(clk),
        .rst(rst),
        .lookValid(lookValid),
        .lookAddr(reqAddr),
        .updValid(updValid),
        .updKind(updKind),
        .updIndex(updIndex),
        .updAddr(updAddr),
        .updData(updData),
        .hitValid(hitValid),
        .hit(hit),
        .hitData(hitData),
        .hitIndex(hitIndex)
    );

    backingStore #(
        .AddrWidth(AddrWidth),
        .DataWidth(DataWidth)
    ) uBackingStore (
        .clk(clk),
        .rst(rst),
        .lookValid(lookValid),
        .lookWrite(reqWrite),
        .lookAddr(reqAddr),
        .lookData(reqData),
        .memValid(memValid),
        .memData(memData)
    );

    readMerge #(
        .AddrWidth(AddrWidth),
        .DataWidth(DataWidth),
        .CellCount(CellCount)
    ) uReadMerge (
        .clk(clk),
        .rst(rst),
        .lookValid(lookValid),
        .lookWrite(reqWrite),
        .lookAddr(reqAddr),
        .lookData(reqData),
        .hitValid(hitValid),
        .hit(hit),
        .hitData(hitData),
        .hitIndex(hitIndex),
        .memValid(memValid),
        .memData(memData),
        .rspReady(rspReady),
        .rspValid(rspValid),
        .rspData(rspData),
        .rspHit(rspHit),
        .updValid(updValid),
        .updKind(updKind),
        .updIndex(updIndex),
        .updAddr(updAddr),
        .updData(updData),
        .busy(busy)
    );

endmodule

`default_nettype wire

/* cacheTop_asserts.sv */
// Cache handshake assertions
`timescale 1ns/10ps
`default_nettype none

module cacheTop_asserts #(
    parameter int DataWidth = cachePkg::DataWidth
) (
    input wire logic                 clk,
    input wire logic                 rst,
    input wire logic                 reqReady,
    input wire logic                 rspValid,
    input wire logic [DataWidth-1:0] rspData,
    input wire logic                 rspReady
);

    int assertFailures = 0;

    // A stalled response keeps its valid and its word
    assert property (@(posedge clk) disable iff (rst)
        (rspValid && !rspReady) |=> (rspValid && $stable(rspData)))
    else begin
        assertFailures++;
        $error("Response changed while the requester held back ready");
    end

    // No new request is taken while a response is pending
    assert property (@(posedge clk) disable iff (rst) rspValid |-> !reqReady)
    else begin
        assertFailures++;
        $error("Request port ready while a response is pending");
    end

    assert property (@(posedge clk) rst |-> !rspValid)
    else begin
        assertFailures++;
        $error("Response valid is high during reset");
    end

endmodule

bind cacheTop cacheTop_asserts #(
    .DataWidth(DataWidth)
) uAsserts (
    .clk(clk),
    .rst(rst),
    .reqReady(reqReady),
    .rspValid(rspValid),
    .rspData(rspData),
    .rspReady(rspReady)
);

`default_nettype wire

/* lruCache.sv */
// Fully associative LRU cache
`timescale 1ns/10ps
`default_nettype none

module lruCache #(
    parameter int AddrWidth = cachePkg::AddrWidth,
    parameter int DataWidth = cachePkg::DataWidth,
    parameter int CellCount = cachePkg::CellCount
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           lookValid,
    input  wire logic [AddrWidth-1:0]           lookAddr,
    input  wire logic                           updValid,
    input  wire logic [cachePkg::KindWidth-1:0] updKind,
    input  wire logic [$clog2(CellCount)-1:0]   updIndex,
    input  wire logic [AddrWidth-1:0]           updAddr,
    input  wire logic [DataWidth-1:0]           updData,
    output logic                                hitValid,
    output logic                                hit,
    output logic      [DataWidth-1:0]           hitData,
    output logic      [$clog2(CellCount)-1:0]   hitIndex
);

    localparam int EntryWidth = AddrWidth + DataWidth;
    localparam int IndexWidth = $clog2(CellCount);

    logic [CellCount*EntryWidth-1:0] cells;
    logic [CellCount-1:0]            cellValid;
    logic [CellCount-1:0]            shiftEn;
    logic [CellCount-1:0]            partialMask;
    logic [CellCount-1:0]            kindMask;
    logic                            matchHit;
    logic [IndexWidth-1:0]           matchIndex;
    logic [DataWidth-1:0]            matchData;

    lruShiftStore #(
        .CellCount(CellCount),
        .EntryWidth(EntryWidth)
    ) uStore (
        .clk(clk),
        .rst(rst),
        .shiftEn(shiftEn),
        .shiftIn({updAddr, updData}),
        .validIn(updValid),
        .cells(cells),
        .cellValid(cellValid)
    );

    // Search every valid cell for the requested address
    // Addresses are unique in the store, so at most one cell matches
    always_comb begin
        matchHit = 1'b0;
        matchIndex = '0;
        matchData = '0;
        for (int i = 0; i < CellCount; i++) begin
            if (cellValid[i] && cells[i*EntryWidth+DataWidth +: AddrWidth] == lookAddr) begin
                matchHit = 1'b1;
                matchIndex = IndexWidth'(i);
                matchData = cells[i*EntryWidth +: DataWidth];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hitValid <= 1'b0;
            hit <= 1'b0;
        end else begin
            hitValid <= lookValid;
            // The hit flag is kept until the next lookup so an insert can use it
            if (lookValid) begin
                hit <= matchHit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookValid) begin
            hitData <= matchData;
            hitIndex <= matchIndex;
        end
    end

    // Cells from the newest one up to the old position of the entry
    always_comb begin
        partialMask = '0;
        for (int i = 0; i < CellCount; i++) begin
            partialMask[i] = (i <= int'(updIndex));
        end
    end

    // A hitting insert overwrites its old slot, every other new entry drops the oldest
    always_comb begin
        case (updKind)
            cachePkg::UpdPromote: kindMask = partialMask;
            cachePkg::UpdFill:    kindMask = '1;
            cachePkg::UpdInsert:  kindMask = hit ? partialMask : '1;
            default:              kindMask = '0;
        endcase
        shiftEn = updValid ? kindMask : '0;
    end

endmodule

`default_nettype wire

/* lruShiftStore.sv */
// Age ordered cell store
`timescale 1ns/10ps
`default_nettype none

module lruShiftStore #(
    parameter int CellCount = cachePkg::CellCount,
    parameter int EntryWidth = cachePkg::EntryWidth
) (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic [CellCount-1:0]            shiftEn,
    input  wire logic [EntryWidth-1:0]           shiftIn,
    input  wire logic                            validIn,
    output logic      [CellCount*EntryWidth-1:0] cells,
    output logic      [CellCount-1:0]            cellValid
);

    // Position 0 is the newest entry, the last position the oldest
    logic [EntryWidth-1:0] entryQ [CellCount];

    // A cell takes part in the tag compare only while its valid bit is set
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cellValid <= '0;
        end else begin
            if (shiftEn[0]) begin
                cellValid[0] <= validIn;
            end
            for (int i = 1; i < CellCount; i++) begin
                if (shiftEn[i]) begin
                    cellValid[i] <= cellValid[i-1];
                end
            end
        end
    end

    // Each enabled cell takes its neighbor from the newer side
    always_ff @(posedge clk) begin
        if (shiftEn[0]) begin
            entryQ[0] <= shiftIn;
        end
        for (int i = 1; i < CellCount; i++) begin
            if (shiftEn[i]) begin
                entryQ[i] <= entryQ[i-1];
            end
        end
    end

    // Flatten the cells for the tag compare
    always_comb begin
        for (int i = 0; i < CellCount; i++) begin
            cells[i*EntryWidth +: EntryWidth] = entryQ[i];
        end
    end

endmodule

`default_nettype wire

/* readMerge.sv */
// Result merge and response control
`timescale 1ns/10ps
`default_nettype none

module readMerge #(
    parameter int AddrWidth = cachePkg::AddrWidth,
    parameter int DataWidth = cachePkg::DataWidth,
    parameter int CellCount = cachePkg::CellCount
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           lookValid,
    input  wire logic                           lookWrite,
    input  wire logic [AddrWidth-1:0]           lookAddr,
    input  wire logic [DataWidth-1:0]           lookData,
    input  wire logic                           hitValid,
    input  wire logic                           hit,
    input  wire logic [DataWidth-1:0]           hitData,
    input  wire logic [$clog2(CellCount)-1:0]   hitIndex,
    input  wire logic                           memValid,
    input  wire logic [DataWidth-1:0]           memData,
    input  wire logic                           rspReady,
    output logic                                rspValid,
    output logic      [DataWidth-1:0]           rspData,
    output logic                                rspHit,
    output logic                                updValid,
    output logic      [cachePkg::KindWidth-1:0] updKind,
    output logic      [$clog2(CellCount)-1:0]   updIndex,
    output logic      [AddrWidth-1:0]           updAddr,
    output logic      [DataWidth-1:0]           updData,
    output logic                                busy
);

    // Idle, wait for results, respond, update the cache, let the update settle
    localparam logic [2:0] StIdle = 3'd0;
    localparam logic [2:0] StWait = 3'd1;
    localparam logic [2:0] StResp = 3'd2;
    localparam logic [2:0] StUpd  = 3'd3;
    localparam logic [2:0] StDone = 3'd4;

    logic [2:0]           state;
    logic                 bothIn;
    logic                 capWrite;
    logic [DataWidth-1:0] capData;
    logic                 capHit;

    // Cache and store register the same lookup, so both results arrive in one cycle
    assign bothIn = hitValid && memValid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= StIdle;
        end else begin
            case (state)
                StIdle: begin
                    if (lookValid) begin
                        state <= StWait;
                    end
                end
                StWait: begin
                    if (bothIn) begin
                        state <= StResp;
                    end
                end
                StResp: begin
                    if (rspReady) begin
                        state <= StUpd;
                    end
                end
                StUpd:   state <= StDone;
                default: state <= StIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookValid) begin
            capWrite <= lookWrite;
            capData <= lookData;
            updAddr <= lookAddr;
        end
        if (hitValid) begin
            capHit <= hit;
            updIndex <= hitIndex;
        end
        // The response word stays put until the requester takes it
        if (state == StWait && bothIn) begin
            rspData <= capWrite ? capData : (hit ? hitData : memData);
        end
    end

    assign rspValid = (state == StResp);
    assign rspHit = capHit;
    assign updValid = (state == StUpd);
    assign updData = rspData;
    assign busy = (state != StIdle);

    always_comb begin
        if (capWrite) begin
            updKind = cachePkg::UpdInsert;
        end else if (capHit) begin
            updKind = cachePkg::UpdPromote;
        end else begin
            updKind = cachePkg::UpdFill;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
cachePkg.sv
lruShiftStore.sv
lruCache.sv
backingStore.sv
readMerge.sv
cacheTop.sv
cacheTop_asserts.sv
tbClock.sv
cacheTb.sv

/* tbClock.sv */
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
    parameter int ClockPeriod = 40,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(ClockPeriod / 2) clk = ~clk;
        end
    end

    // Reset leaves shortly after a rising edge
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire
